/* flist.f */
design/bru_isa_pkg.sv
design/bru_cfg_pkg.sv
design/bru_issue_if.sv
design/bru_resolve_if.sv
design/bru_issue_stage.sv
design/bru_resolve.sv
design/bru_redirect.sv
design/bru_bht.sv
design/bru_top.sv
verification/bru_tb.sv

/* Makefile */
# Verilator build and run of the branch unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= bru_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verification/bru_tb.sv */
// Testbench for the branch resolution unit.
// Drives random and directed control-flow instructions and checks every
// result against a cycle model of the pipeline and its predictor.

`timescale 1ns/1ns
`default_nettype none

module bru_tb;
  import bru_isa_pkg::*;

  localparam int          XLEN       = 32;
  localparam int          HIST_BITS  = 4;
  localparam int          ENTRIES    = 2**HIST_BITS;
  localparam logic [31:0] PC_INIT    = 32'h0000_0200;
  localparam logic [31:0] LOOP_PC    = 32'h0000_0400;
  localparam int          N_INSN     = 400;
  // Ten clocks per instruction leaves room for stalls and squashes
  localparam int          MAX_CYCLES = N_INSN * 10;

  // Operation kinds known to the stimulus
  localparam int K_NONE   = 0;
  localparam int K_BR     = 1;
  localparam int K_JAL    = 2;
  localparam int K_JALR   = 3;
  localparam int K_FENCEI = 4;

  logic        clk_i;
  logic        rst_ni;
  logic        stall_i;
  logic        valid_i;
  logic [31:0] pc_i;
  logic [31:0] insn_i;
  logic [31:0] opa_i;
  logic [31:0] opb_i;
  logic        valid_o;
  logic [31:0] nxt_pc_o;
  logic        flush_o;
  logic        ic_invalidate_o;
  logic        dc_clean_o;
  logic        misaligned_o;
  logic        taken_o;

  // What the stimulus put on the bus, as seen by the model
  int          drv_kind;
  logic [2:0]  drv_f3;
  logic [31:0] drv_imm;
  logic        drv_tail;

  // Model issue slot
  logic                 m_iv;
  logic [31:0]          m_pc;
  logic [31:0]          m_opa;
  logic [31:0]          m_opb;
  logic [31:0]          m_imm;
  int                   m_kind;
  logic [2:0]           m_f3;
  logic                 m_pred;
  logic                 m_tail;
  logic [HIST_BITS-1:0] m_idx;

  // Model redirect slot
  logic                 exp_valid;
  logic                 exp_flush;
  logic                 exp_ic;
  logic                 exp_taken;
  logic                 exp_mis;
  logic                 exp_train;
  logic                 exp_tail;
  logic [31:0]          exp_pc;
  logic [HIST_BITS-1:0] exp_idx;

  // Model predictor
  logic [1:0]           m_pht [ENTRIES];
  logic [HIST_BITS-1:0] m_hist;

  int          sent;
  int          cycles = 0;
  int unsigned seed_val;

  bru_top #(.XLEN(XLEN), .HIST_BITS(HIST_BITS), .PC_INIT(PC_INIT)) dut0 (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .stall_i         (stall_i),
    .valid_i         (valid_i),
    .pc_i            (pc_i),
    .insn_i          (insn_i),
    .opa_i           (opa_i),
    .opb_i           (opb_i),
    .valid_o         (valid_o),
    .nxt_pc_o        (nxt_pc_o),
    .flush_o         (flush_o),
    .ic_invalidate_o (ic_invalidate_o),
    .dc_clean_o      (dc_clean_o),
    .misaligned_o    (misaligned_o),
    .taken_o         (taken_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encoders and random picks
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] enc_branch(input logic [2:0] f3, input logic [12:0] imm);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
  endfunction

  function automatic logic [31:0] enc_jalr(input logic [11:0] imm);
    return {imm, 5'd1, 3'b000, 5'd1, OPC_JALR};
  endfunction

  function automatic logic [2:0] pick_f3();
    logic [2:0] f3;
    case ($urandom % 6)
      0:       f3 = F3_BEQ;
      1:       f3 = F3_BNE;
      2:       f3 = F3_BLT;
      3:       f3 = F3_BGE;
      4:       f3 = F3_BLTU;
      default: f3 = F3_BGEU;
    endcase
    return f3;
  endfunction

  function automatic logic [31:0] pick_operand(input logic [31:0] other);
    logic [31:0] r;
    logic [31:0] v;
    r = $urandom;
    case ($urandom % 4)
      0:       v = other;
      1:       v = {1'b1, r[30:0]};
      // Close to the other operand, wraps when that one sits near the top
      2:       v = other + {28'd0, r[3:0]};
      default: v = r;
    endcase
    return v;
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    logic t;
    case (f3)
      F3_BEQ:  t = (a == b);
      F3_BNE:  t = (a != b);
      F3_BLT:  t = ($signed(a) < $signed(b));
      F3_BGE:  t = ($signed(a) >= $signed(b));
      F3_BLTU: t = (a < b);
      default: t = (a >= b);
    endcase
    return t;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////
  task automatic drive_random_insn();
    logic [31:0] r;
    int          pick;
    r        = $urandom;
    pick     = $urandom % 10;
    stall_i  = (($urandom % 5) == 0);
    valid_i  = (($urandom % 8) != 0);
    pc_i     = {r[31:2], 2'b00};
    opa_i    = (($urandom % 4) == 0) ? 32'hFFFF_FFF8 : $urandom;
    opb_i    = pick_operand(opa_i);
    drv_tail = 1'b0;
    r        = $urandom;
    if (pick < 5) begin
      drv_kind = K_BR;
      drv_f3   = pick_f3();
      drv_imm  = {{19{r[12]}}, r[12:1], 1'b0};
      insn_i   = enc_branch(drv_f3, drv_imm[12:0]);
    end else if (pick < 7) begin
      drv_kind = K_JAL;
      drv_imm  = {{11{r[20]}}, r[20:1], 1'b0};
      insn_i   = enc_jal(drv_imm[20:0]);
    end else if (pick < 8) begin
      drv_kind = K_JALR;
      drv_imm  = {{20{r[11]}}, r[11:0]};
      insn_i   = enc_jalr(drv_imm[11:0]);
    end else if (pick < 9) begin
      drv_kind = K_FENCEI;
      drv_imm  = 32'd0;
      insn_i   = FENCE_I;
    end else begin
      // Plain FENCE, a MISC-MEM word with no cache effect
      drv_kind = K_NONE;
      drv_imm  = 32'd0;
      insn_i   = 32'h0FF0_000F;
    end
  endtask

  // Backward BNE that is always taken
  task automatic drive_loop_insn(input logic tail);
    stall_i  = 1'b0;
    valid_i  = 1'b1;
    pc_i     = LOOP_PC;
    opa_i    = 32'd3;
    opb_i    = 32'd7;
    drv_kind = K_BR;
    drv_f3   = F3_BNE;
    drv_imm  = 32'hFFFF_FFF0;
    drv_tail = tail;
    insn_i   = enc_branch(F3_BNE, drv_imm[12:0]);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////
  task automatic reset_model();
    for (int i = 0; i < ENTRIES; i++) begin
      m_pht[i] = 2'b01;
    end
    m_hist    = '0;
    m_iv      = 1'b0;
    exp_valid = 1'b0;
    // Reset redirects fetch once
    exp_flush = 1'b1;
    exp_ic    = 1'b0;
    exp_taken = 1'b0;
    exp_mis   = 1'b0;
    exp_train = 1'b0;
    exp_tail  = 1'b0;
    exp_pc    = PC_INIT;
    exp_idx   = '0;
  endtask

  task automatic step_model();
    logic [HIST_BITS-1:0] idx;
    logic                 pred;
    logic                 kill;
    logic [31:0]          tgt;
    logic                 tk;
    logic                 fl;
    idx  = pc_i[HIST_BITS+1:2] ^ m_hist;
    pred = m_pht[idx][1];
    kill = exp_flush;
    // Train with the result leaving the redirect slot
    if (exp_train) begin
      if (exp_taken && m_pht[exp_idx] != 2'b11) begin
        m_pht[exp_idx] = m_pht[exp_idx] + 2'd1;
      end else if (!exp_taken && m_pht[exp_idx] != 2'b00) begin
        m_pht[exp_idx] = m_pht[exp_idx] - 2'd1;
      end
      m_hist = {m_hist[HIST_BITS-2:0], exp_taken};
    end
    tgt       = m_pc + 32'd4;
    tk        = 1'b0;
    fl        = 1'b0;
    exp_ic    = 1'b0;
    exp_train = 1'b0;
    if (m_iv) begin
      case (m_kind)
        K_BR: begin
          tk        = branch_taken(m_f3, m_opa, m_opb);
          tgt       = tk ? m_pc + m_imm : m_pc + 32'd4;
          fl        = tk ^ m_pred;
          exp_train = 1'b1;
        end
        K_JAL: begin
          tk  = 1'b1;
          tgt = m_pc + m_imm;
          fl  = ~m_pred;
        end
        K_JALR: begin
          tk  = 1'b1;
          tgt = (m_opa + m_imm) & ~32'd1;
          fl  = 1'b1;
        end
        K_FENCEI: begin
          fl     = 1'b1;
          exp_ic = 1'b1;
        end
        default: ;
      endcase
      exp_pc = tgt;
    end
    exp_valid = m_iv;
    exp_taken = m_iv & tk;
    exp_flush = m_iv & fl;
    exp_mis   = m_iv & tk & (tgt[1:0] != 2'b00);
    exp_tail  = m_iv & m_tail;
    exp_idx   = m_idx;
    // New word is squashed while a redirect leaves
    m_iv   = valid_i & ~kill;
    m_pc   = pc_i;
    m_opa  = opa_i;
    m_opb  = opb_i;
    m_kind = drv_kind;
    m_f3   = drv_f3;
    m_imm  = drv_imm;
    m_pred = pred;
    m_idx  = idx;
    m_tail = drv_tail;
  endtask

  task automatic check_reset_state();
    assert (flush_o && !valid_o && nxt_pc_o == PC_INIT && !ic_invalidate_o && !dc_clean_o
            && !misaligned_o && !taken_o)
      else fail_run($sformatf("mismatch at %0t: outputs are not at reset values", $time));
  endtask

  task automatic check_outputs();
    logic v_exp;
    logic s_exp;
    v_exp = exp_valid & ~stall_i;
    s_exp = exp_ic & ~stall_i;
    assert (valid_o == v_exp)
      else fail_run($sformatf("mismatch at %0t: valid_o %0b, expected %0b", $time, valid_o,
                              v_exp));
    assert (nxt_pc_o == exp_pc)
      else fail_run($sformatf("mismatch at %0t: nxt_pc_o %h, expected %h", $time, nxt_pc_o,
                              exp_pc));
    assert (taken_o == exp_taken)
      else fail_run($sformatf("mismatch at %0t: taken_o %0b, expected %0b", $time, taken_o,
                              exp_taken));
    assert (misaligned_o == exp_mis)
      else fail_run($sformatf("mismatch at %0t: misaligned_o %0b, expected %0b", $time,
                              misaligned_o, exp_mis));
    assert (ic_invalidate_o == s_exp && dc_clean_o == s_exp)
      else fail_run($sformatf("mismatch at %0t: cache strobes %0b%0b, expected %0b", $time,
                              ic_invalidate_o, dc_clean_o, s_exp));
    if (valid_o) begin
      assert (flush_o == exp_flush)
        else fail_run($sformatf("mismatch at %0t: flush_o %0b, expected %0b", $time, flush_o,
                                exp_flush));
      assert (!(exp_tail && flush_o))
        else fail_run("The loop branch kept flushing after its counter should have saturated");
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      reset_model();
    end else begin
      check_outputs();
      if (!stall_i) begin
        step_model();
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      fail_run("Timeout: the run did not finish within the cycle limit");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    seed_val = $urandom(80747);
    rst_ni   = 1'b0;
    stall_i  = 1'b0;
    valid_i  = 1'b0;
    pc_i     = 32'd0;
    insn_i   = 32'd0;
    opa_i    = 32'd0;
    opb_i    = 32'd0;
    drv_kind = K_NONE;
    drv_f3   = 3'd0;
    drv_imm  = 32'd0;
    drv_tail = 1'b0;
    sent     = 0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    check_reset_state();
    rst_ni = 1'b1;
    // Random mix, then a hot loop, then random mix again
    while (sent < N_INSN) begin
      if (sent >= 200 && sent < 280) begin
        drive_loop_insn(sent >= 240);
      end else begin
        drive_random_insn();
      end
      if (valid_i && !stall_i) begin
        sent++;
      end
      @(negedge clk_i);
    end
    valid_i = 1'b0;
    stall_i = 1'b0;
    while (m_iv || exp_valid) begin
      @(negedge clk_i);
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* design/bru_top.sv */
// Branch resolution unit top level.
// Issue register, resolver, redirect register and predictor in one slice.

`timescale 1ns/1ns
`default_nettype none

module bru_top #(
  parameter int              XLEN      = bru_cfg_pkg::DEF_XLEN,
  parameter int              HIST_BITS = bru_cfg_pkg::DEF_HIST_BITS,
  parameter logic [XLEN-1:0] PC_INIT   = bru_cfg_pkg::DEF_PC_INIT
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            stall_i,
  input  logic            valid_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [31:0]     insn_i,
  input  logic [XLEN-1:0] opa_i,
  input  logic [XLEN-1:0] opb_i,
  output logic            valid_o,
  output logic [XLEN-1:0] nxt_pc_o,
  output logic            flush_o,
  output logic            ic_invalidate_o,
  output logic            dc_clean_o,
  output logic            misaligned_o,
  output logic            taken_o
);
  import bru_cfg_pkg::*;

  logic [HIST_BITS-1:0] lookup_index;
  logic [HIST_BITS-1:0] history;
  ctr_t                 lookup_ctr;
  logic                 train;
  logic [HIST_BITS-1:0] train_index;

  bru_issue_if   #(.XLEN(XLEN), .HIST_BITS(HIST_BITS)) issue_bus ();
  bru_resolve_if #(.XLEN(XLEN), .HIST_BITS(HIST_BITS)) res_bus ();

  bru_issue_stage #(.XLEN(XLEN), .HIST_BITS(HIST_BITS)) u_issue (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .stall_i   (stall_i),
    .valid_i   (valid_i),
    .pc_i      (pc_i),
    .insn_i    (insn_i),
    .opa_i     (opa_i),
    .opb_i     (opb_i),
    .kill_i    (flush_o),
    .history_i (history),
    .ctr_i     (lookup_ctr),
    .index_o   (lookup_index),
    .issue     (issue_bus)
  );

  bru_resolve #(.XLEN(XLEN)) u_resolve (
    .issue (issue_bus),
    .res   (res_bus)
  );

  bru_redirect #(.XLEN(XLEN), .HIST_BITS(HIST_BITS), .PC_INIT(PC_INIT)) u_redirect (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .stall_i         (stall_i),
    .res             (res_bus),
    .valid_o         (valid_o),
    .nxt_pc_o        (nxt_pc_o),
    .flush_o         (flush_o),
    .ic_invalidate_o (ic_invalidate_o),
    .dc_clean_o      (dc_clean_o),
    .misaligned_o    (misaligned_o),
    .taken_o         (taken_o),
    .train_o         (train),
    .train_index_o   (train_index)
  );

  // Trained from the registered result
  bru_bht #(.HIST_BITS(HIST_BITS)) u_bht (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .stall_i        (stall_i),
    .lookup_index_i (lookup_index),
    .train_i        (train),
    .taken_i        (taken_o),
    .train_index_i  (train_index),
    .history_o      (history),
    .ctr_o          (lookup_ctr)
  );

endmodule

`default_nettype wire

/* design/bru_bht.sv */
// Global history branch predictor.
// Pattern table of two-bit saturating counters and the global history register.

`timescale 1ns/1ns
`default_nettype none

module bru_bht #(
  parameter int HIST_BITS = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 stall_i,
  input  logic [HIST_BITS-1:0] lookup_index_i,
  input  logic                 train_i,
  input  logic                 taken_i,
  input  logic [HIST_BITS-1:0] train_index_i,
  output logic [HIST_BITS-1:0] history_o,
  output bru_cfg_pkg::ctr_t    ctr_o
);
  import bru_cfg_pkg::*;

  localparam int ENTRIES = 2**HIST_BITS;

  ctr_t                 pht_q [ENTRIES];
  ctr_t                 ctr_cur;
  ctr_t                 ctr_next;
  logic [HIST_BITS-1:0] history_q;

  assign ctr_cur = pht_q[train_index_i];

  // Saturating step toward the resolved direction
  always_comb begin
    ctr_next = ctr_cur;
    if (taken_i && ctr_cur != 2'b11) begin
      ctr_next = ctr_cur + 2'b01;
    end else if (!taken_i && ctr_cur != 2'b00) begin
      ctr_next = ctr_cur - 2'b01;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      history_q <= '0;
      for (int i = 0; i < ENTRIES; i++) begin
        pht_q[i] <= CTR_RESET;
      end
    end else if (train_i && !stall_i) begin
      pht_q[train_index_i] <= ctr_next;
      history_q            <= {history_q[HIST_BITS-2:0], taken_i};
    end
  end

  assign history_o = history_q;
  assign ctr_o     = pht_q[lookup_index_i];

endmodule

`default_nettype wire

/* design/bru_redirect.sv */
// Branch unit output register stage.
// Holds next PC, flush, cache strobes and training for one cycle per result.

`timescale 1ns/1ns
`default_nettype none

module bru_redirect #(
  parameter int              XLEN      = 32,
  parameter int              HIST_BITS = 4,
  parameter logic [XLEN-1:0] PC_INIT   = 'h200
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 stall_i,
  bru_resolve_if.in            res,
  output logic                 valid_o,
  output logic [XLEN-1:0]      nxt_pc_o,
  output logic                 flush_o,
  output logic                 ic_invalidate_o,
  output logic                 dc_clean_o,
  output logic                 misaligned_o,
  output logic                 taken_o,
  output logic                 train_o,
  output logic [HIST_BITS-1:0] train_index_o
);

  logic valid_q;
  logic flush_q;
  logic ic_inv_q;
  logic dc_clean_q;
  logic train_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q      <= 1'b0;
      // Send fetch to the reset vector
      flush_q      <= 1'b1;
      ic_inv_q     <= 1'b0;
      dc_clean_q   <= 1'b0;
      misaligned_o <= 1'b0;
      taken_o      <= 1'b0;
      train_q      <= 1'b0;
      nxt_pc_o     <= PC_INIT;
    end else if (!stall_i) begin
      valid_q      <= res.valid;
      flush_q      <= res.flush;
      ic_inv_q     <= res.ic_invalidate;
      dc_clean_q   <= res.dc_clean;
      misaligned_o <= res.misaligned;
      taken_o      <= res.taken;
      train_q      <= res.train;
      if (res.valid) begin
        nxt_pc_o <= res.nxt_pc;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      train_index_o <= res.bht_index;
    end
  end

  // A held result is reported once, on the cycle the stall lifts
  assign valid_o         = valid_q & ~stall_i;
  assign flush_o         = flush_q & ~stall_i;
  assign ic_invalidate_o = ic_inv_q & ~stall_i;
  assign dc_clean_o      = dc_clean_q & ~stall_i;
  assign train_o         = train_q & ~stall_i;

endmodule

`default_nettype wire

/* design/bru_resolve.sv */
// Branch resolver.
// Evaluates branch conditions and jump targets, then decides on flush,
// cache maintenance and predictor training for the issued instruction.

`timescale 1ns/1ns
`default_nettype none

module bru_resolve #(
  parameter int XLEN = 32
) (
  bru_issue_if.in    issue,
  bru_resolve_if.out res
);
  import bru_isa_pkg::*;
  import bru_cfg_pkg::*;

  logic            eq;
  logic            lt;
  logic            ltu;
  logic            cond;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] seq_pc;
  logic [XLEN-1:0] jalr_sum;
  logic [XLEN-1:0] nxt_pc;
  logic            taken;
  logic            flush;
  logic            cache_op;
  logic            train;

  // Comparators shared by all six conditions
  assign eq  = (issue.opa == issue.opb);
  assign lt  = ($signed(issue.opa) < $signed(issue.opb));
  assign ltu = (issue.opa < issue.opb);

  assign target   = issue.pc + issue.imm;
  assign seq_pc   = issue.pc + XLEN'(4);
  assign jalr_sum = issue.opa + issue.imm;

  always_comb begin
    case (issue.insn.r.funct3)
      F3_BEQ:  cond = eq;
      F3_BNE:  cond = ~eq;
      F3_BLT:  cond = lt;
      F3_BGE:  cond = ~lt;
      F3_BLTU: cond = ltu;
      F3_BGEU: cond = ~ltu;
      default: cond = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Redirect decision
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    nxt_pc   = seq_pc;
    taken    = 1'b0;
    flush    = 1'b0;
    cache_op = 1'b0;
    train    = 1'b0;
    case (issue.op)
      OP_BRANCH: begin
        taken  = cond;
        train  = 1'b1;
        // Mispredicted in either direction
        flush  = cond ^ issue.predict;
        nxt_pc = cond ? target : seq_pc;
      end
      OP_JAL: begin
        taken  = 1'b1;
        flush  = ~issue.predict;
        nxt_pc = target;
      end
      OP_JALR: begin
        // Register target is never predicted
        taken  = 1'b1;
        flush  = 1'b1;
        nxt_pc = {jalr_sum[XLEN-1:1], 1'b0};
      end
      OP_FENCEI: begin
        flush    = 1'b1;
        cache_op = 1'b1;
      end
      default: taken = 1'b0;
    endcase
  end

  assign res.valid         = issue.valid;
  assign res.nxt_pc        = nxt_pc;
  assign res.taken         = issue.valid & taken;
  assign res.flush         = issue.valid & flush;
  assign res.misaligned    = issue.valid & taken & (|nxt_pc[1:0]);
  assign res.ic_invalidate = issue.valid & cache_op;
  assign res.dc_clean      = issue.valid & cache_op;
  assign res.train         = issue.valid & train;
  assign res.bht_index     = issue.bht_index;

endmodule

`default_nettype wire

/* design/bru_issue_stage.sv */
// Branch unit issue stage.
// Classifies the instruction, builds its immediate, looks up the predictor
// and registers the result for the resolver.

`timescale 1ns/1ns
`default_nettype none

module bru_issue_stage #(
  parameter int XLEN      = 32,
  parameter int HIST_BITS = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 stall_i,
  input  logic                 valid_i,
  input  logic [XLEN-1:0]      pc_i,
  input  bru_isa_pkg::insn_u   insn_i,
  input  logic [XLEN-1:0]      opa_i,
  input  logic [XLEN-1:0]      opb_i,
  input  logic                 kill_i,
  input  logic [HIST_BITS-1:0] history_i,
  input  bru_cfg_pkg::ctr_t    ctr_i,
  output logic [HIST_BITS-1:0] index_o,
  bru_issue_if.out             issue
);
  import bru_isa_pkg::*;
  import bru_cfg_pkg::*;

  op_class_e       op;
  logic [XLEN-1:0] imm;

  // Word address bits folded with global history
  assign index_o = pc_i[HIST_BITS+1:2] ^ history_i;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    op  = OP_NONE;
    imm = '0;
    case (insn_i.r.opcode)
      OPC_BRANCH: begin
        // funct3 010 and 011 are not branches
        if (insn_i.r.funct3[2:1] != 2'b01) begin
          op = OP_BRANCH;
        end
        imm = {{(XLEN-12){insn_i.b.imm12}}, insn_i.b.imm11, insn_i.b.imm10_5,
               insn_i.b.imm4_1, 1'b0};
      end
      OPC_JAL: begin
        op  = OP_JAL;
        imm = {{(XLEN-20){insn_i.j.imm20}}, insn_i.j.imm19_12, insn_i.j.imm11,
               insn_i.j.imm10_1, 1'b0};
      end
      OPC_JALR: begin
        op  = OP_JALR;
        imm = {{(XLEN-12){insn_i.i.imm[11]}}, insn_i.i.imm};
      end
      OPC_MISCMEM: begin
        if (insn_i == FENCE_I) begin
          op = OP_FENCEI;
        end
      end
      default: op = OP_NONE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Issue register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue.valid <= 1'b0;
    end else if (!stall_i) begin
      // A pending redirect squashes whatever arrives now
      issue.valid <= valid_i & ~kill_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      issue.pc        <= pc_i;
      issue.opa       <= opa_i;
      issue.opb       <= opb_i;
      issue.insn      <= insn_i;
      issue.op        <= op;
      issue.imm       <= imm;
      issue.predict   <= ctr_i[1];
      issue.bht_index <= index_o;
    end
  end

endmodule

`default_nettype wire

/* design/bru_resolve_if.sv */
// Resolution bus from the resolver to the redirect register stage.
// One resolved instruction per cycle with its redirect and training info.

`timescale 1ns/1ns
`default_nettype none

interface bru_resolve_if #(
  parameter int XLEN      = 32,
  parameter int HIST_BITS = 4
);

  logic                 valid;
  logic [XLEN-1:0]      nxt_pc;
  logic                 flush;
  logic                 taken;
  logic                 misaligned;
  logic                 ic_invalidate;
  logic                 dc_clean;
  logic                 train;
  logic [HIST_BITS-1:0] bht_index;

  modport out (output valid, nxt_pc, flush, taken, misaligned, ic_invalidate, dc_clean,
                      train, bht_index);
  modport in  (input  valid, nxt_pc, flush, taken, misaligned, ic_invalidate, dc_clean,
                      train, bht_index);

endinterface

`default_nettype wire

/* design/bru_issue_if.sv */
// Issue bus from the issue register to the resolver.
// Carries one decoded instruction with its operands and prediction.

`timescale 1ns/1ns
`default_nettype none

interface bru_issue_if #(
  parameter int XLEN      = 32,
  parameter int HIST_BITS = 4
);
  import bru_isa_pkg::*;
  import bru_cfg_pkg::*;

  logic                 valid;
  logic [XLEN-1:0]      pc;
  logic [XLEN-1:0]      opa;
  logic [XLEN-1:0]      opb;
  insn_u                insn;
  op_class_e            op;
  logic [XLEN-1:0]      imm;
  logic                 predict;
  logic [HIST_BITS-1:0] bht_index;

  modport out (output valid, pc, opa, opb, insn, op, imm, predict, bht_index);
  modport in  (input  valid, pc, opa, opb, insn, op, imm, predict, bht_index);

endinterface

`default_nettype wire

/* design/bru_cfg_pkg.sv */
// Branch unit configuration.
// Operation classes, predictor counter type and default top-level settings.

`default_nettype none

package bru_cfg_pkg;

  // What the resolver has to do with an issued word
  typedef enum logic [2:0] {
    OP_NONE   = 3'd0,
    OP_BRANCH = 3'd1,
    OP_JAL    = 3'd2,
    OP_JALR   = 3'd3,
    OP_FENCEI = 3'd4
  } op_class_e;

  // Two-bit saturating counter, bit 1 is the taken prediction
  typedef logic [1:0] ctr_t;

  // Weakly not taken
  localparam ctr_t CTR_RESET = 2'b01;

  // Top-level defaults
  localparam int          DEF_XLEN      = 32;
  localparam int          DEF_HIST_BITS = 4;
  localparam logic [31:0] DEF_PC_INIT   = 32'h0000_0200;

endpackage

`default_nettype wire

/* design/bru_isa_pkg.sv */
// RV32I instruction set definitions used by the branch unit.
// Opcodes, branch condition codes and the decoded views of one instruction word.

`default_nettype none

package bru_isa_pkg;

  // Major opcodes handled by the branch unit
  localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
  localparam logic [6:0] OPC_JAL     = 7'b1101111;
  localparam logic [6:0] OPC_JALR    = 7'b1100111;
  localparam logic [6:0] OPC_MISCMEM = 7'b0001111;

  // Branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // The one MISC-MEM word that touches the caches
  localparam logic [31:0] FENCE_I = 32'h0000_100F;

  // One instruction word, four ways of looking at it
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [19:0] rest;
    } i;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } insn_u;

endpackage

`default_nettype wire
